/* Makefile */
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module umi_mem_tb -f umi_mem.f -o umi_mem_sim

run: compile
	./obj_dir/umi_mem_sim | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG) || ! grep -q ">>> PASS" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* hdl/umi_endpoint.sv */
`default_nettype none

module umi_endpoint
   import umi_pkg::*;
(
   input  logic              clk,
   input  logic              nreset,
   // Request in
   input  logic              req_valid,
   input  logic [UMI_UW-1:0] req_packet,
   output logic              req_ready,
   // Memory side
   output logic              mem_write,
   output logic              mem_read,
   output logic [WORD_W-1:0] mem_index,
   output logic [UMI_DW-1:0] mem_wdata,
   input  logic              mem_ready,
   input  logic [UMI_DW-1:0] mem_rdata,
   // Response out
   output logic              rsp_valid,
   output logic [UMI_UW-1:0] rsp_packet,
   input  logic              rsp_ready
);

   //####################################################################
   // Unpack and decode
   //####################################################################
   logic [CMD_W-1:0]    cmd;
   logic [OPCODE_W-1:0] cmd_opcode;
   logic [SIZE_W-1:0]   cmd_size;
   logic [USER_W-1:0]   cmd_user;
   logic [UMI_AW-1:0]   dstaddr;
   logic [UMI_AW-1:0]   srcaddr;
   logic [UMI_DW-1:0]   data;
   logic                cmd_read;
   logic                cmd_write;
   logic                cmd_invalid;

   assign cmd        = req_packet[CMD_LSB +: CMD_W];
   assign dstaddr    = req_packet[DST_LSB +: UMI_AW];
   assign srcaddr    = req_packet[SRC_LSB +: UMI_AW];
   assign data       = req_packet[DATA_LSB +: UMI_DW];
   assign cmd_opcode = cmd[OPCODE_LSB +: OPCODE_W];
   assign cmd_size   = cmd[SIZE_LSB +: SIZE_W];
   assign cmd_user   = cmd[USER_LSB +: USER_W];

   assign cmd_read    = (cmd_opcode == OP_READ);
   assign cmd_write   = (cmd_opcode == OP_WRITE);
   assign cmd_invalid = ~cmd_read & ~cmd_write;   // Dropped silently

   // Invalid ops are swallowed even while memory is busy
   assign req_ready = cmd_invalid | (mem_ready & (~cmd_read | rsp_ready));

   // Pulses only on the transfer cycle
   assign mem_write = req_valid & cmd_write & mem_ready;
   assign mem_read  = req_valid & cmd_read & mem_ready & rsp_ready;
   assign mem_index = dstaddr[WORD_LSB +: WORD_W];
   assign mem_wdata = data;

   //####################################################################
   // Read turnaround
   //####################################################################
   logic                rsp_valid_q;
   logic [UMI_AW-1:0]   dst_q;                    // Request source becomes dest
   logic [SIZE_W-1:0]   size_q;
   logic [USER_W-1:0]   user_q;
   logic [UMI_DW-1:0]   rdata_q;                  // Response data register

   // Holds while the arbiter stalls
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         rsp_valid_q <= 1'b0;
      else if (rsp_ready)
         rsp_valid_q <= mem_read;
   end

   always_ff @(posedge clk)
   begin
      if (mem_read)
      begin
         dst_q   <= srcaddr;
         size_q  <= cmd_size;
         user_q  <= cmd_user;
         rdata_q <= mem_rdata;
      end
   end

   // Pack response, source field left at zero
   always_comb
   begin
      rsp_packet = '0;
      rsp_packet[CMD_LSB+OPCODE_LSB +: OPCODE_W] = OP_RESP_READ;
      rsp_packet[CMD_LSB+SIZE_LSB +: SIZE_W]     = size_q;
      rsp_packet[CMD_LSB+USER_LSB +: USER_W]     = user_q;
      rsp_packet[DST_LSB +: UMI_AW]              = dst_q;
      rsp_packet[DATA_LSB +: UMI_DW]             = rdata_q;
   end

   assign rsp_valid = rsp_valid_q;

endmodule

`default_nettype wire

/* hdl/umi_mem_subsystem.sv */
`default_nettype none

module umi_mem_subsystem
   import umi_pkg::*;
(
   input  logic              clk,
   input  logic              nreset,
   // Request port
   input  logic              in_valid,
   input  logic [UMI_UW-1:0] in_packet,
   output logic              in_ready,
   // Response port
   output logic              out_valid,
   output logic [UMI_UW-1:0] out_packet,
   input  logic              out_ready
);

   // Router to endpoints
   logic [N_ENDPOINTS-1:0]             req_valid;
   logic [UMI_UW-1:0]                  req_packet;
   logic [N_ENDPOINTS-1:0]             req_ready;
   // Endpoint to memory
   logic [N_ENDPOINTS-1:0]             mem_write;
   logic [N_ENDPOINTS-1:0]             mem_read;
   logic [N_ENDPOINTS-1:0][WORD_W-1:0] mem_index;
   logic [N_ENDPOINTS-1:0][UMI_DW-1:0] mem_wdata;
   logic [N_ENDPOINTS-1:0]             mem_ready;
   logic [N_ENDPOINTS-1:0][UMI_DW-1:0] mem_rdata;
   // Endpoints to arbiter
   logic [N_ENDPOINTS-1:0]             rsp_valid;
   logic [N_ENDPOINTS-1:0][UMI_UW-1:0] rsp_packet;
   logic [N_ENDPOINTS-1:0]             rsp_ready;

   //####################################################################
   // Request steering
   //####################################################################
   umi_request_router router_i (
      .clk       (clk),
      .nreset    (nreset),
      .in_valid  (in_valid),
      .in_packet (in_packet),
      .in_ready  (in_ready),
      .ep_valid  (req_valid),
      .ep_packet (req_packet),
      .ep_ready  (req_ready)
   );

   //####################################################################
   // Endpoint and memory pairs
   //####################################################################
   for (genvar i = 0; i < N_ENDPOINTS; i++)
   begin : g_ep
      umi_endpoint endpoint_i (
         .clk        (clk),
         .nreset     (nreset),
         .req_valid  (req_valid[i]),
         .req_packet (req_packet),
         .req_ready  (req_ready[i]),
         .mem_write  (mem_write[i]),
         .mem_read   (mem_read[i]),
         .mem_index  (mem_index[i]),
         .mem_wdata  (mem_wdata[i]),
         .mem_ready  (mem_ready[i]),
         .mem_rdata  (mem_rdata[i]),
         .rsp_valid  (rsp_valid[i]),
         .rsp_packet (rsp_packet[i]),
         .rsp_ready  (rsp_ready[i])
      );

      umi_scratch_mem mem_i (
         .clk    (clk),
         .nreset (nreset),
         .write  (mem_write[i]),
         .read   (mem_read[i]),
         .index  (mem_index[i]),
         .wdata  (mem_wdata[i]),
         .ready  (mem_ready[i]),
         .rdata  (mem_rdata[i])
      );
   end

   // Response merge
   umi_response_arbiter arbiter_i (
      .clk        (clk),
      .nreset     (nreset),
      .ep_valid   (rsp_valid),
      .ep_packet  (rsp_packet),
      .ep_ready   (rsp_ready),
      .out_valid  (out_valid),
      .out_packet (out_packet),
      .out_ready  (out_ready)
   );

endmodule

`default_nettype wire

/* hdl/umi_pkg.sv */
`default_nettype none

package umi_pkg;

   //####################################################################
   // Bus widths
   //####################################################################
   localparam int UMI_AW = 32;                 // Address width
   localparam int UMI_DW = 32;                 // Data width
   localparam int UMI_UW = 128;                // Whole packet

   //####################################################################
   // Packet layout
   //####################################################################
   localparam int CMD_LSB  = 0;                // Command word
   localparam int CMD_W    = 32;
   localparam int DST_LSB  = 32;               // Destination address
   localparam int SRC_LSB  = 64;               // Source address
   localparam int DATA_LSB = 96;               // Payload data

   // Offsets inside the command word
   localparam int OPCODE_LSB = 0;
   localparam int OPCODE_W   = 8;
   localparam int SIZE_LSB   = 8;
   localparam int SIZE_W     = 4;
   localparam int USER_LSB   = 12;
   localparam int USER_W     = 20;

   //####################################################################
   // Opcodes
   //####################################################################
   localparam logic [OPCODE_W-1:0] OP_READ      = 8'h01;   // Read request
   localparam logic [OPCODE_W-1:0] OP_WRITE     = 8'h05;   // Posted write
   localparam logic [OPCODE_W-1:0] OP_RESP_READ = 8'h02;   // Read response

   //####################################################################
   // Subsystem sizes
   //####################################################################
   localparam int N_ENDPOINTS = 4;             // Endpoint and memory pairs
   localparam int EP_SEL_W    = $clog2(N_ENDPOINTS);
   localparam int EP_SEL_LSB  = 8;             // Dest addr bits 9:8 pick endpoint

   localparam int MEM_WORDS   = 16;            // Words per scratch memory
   localparam int WORD_W      = $clog2(MEM_WORDS);
   localparam int WORD_LSB    = 2;             // Byte address to word index

endpackage

`default_nettype wire

/* hdl/umi_request_router.sv */
`default_nettype none

module umi_request_router
   import umi_pkg::*;
(
   input  logic                   clk,
   input  logic                   nreset,
   // Incoming requests
   input  logic                   in_valid,
   input  logic [UMI_UW-1:0]      in_packet,
   output logic                   in_ready,
   // Toward the endpoints
   output logic [N_ENDPOINTS-1:0] ep_valid,
   output logic [UMI_UW-1:0]      ep_packet,     // Shared by all endpoints
   input  logic [N_ENDPOINTS-1:0] ep_ready
);

   logic                run_q;                   // Set once out of reset
   logic                valid_q;                 // Buffer holds a request
   logic [UMI_UW-1:0]   packet_q;
   logic [EP_SEL_W-1:0] sel_q;                   // Decoded target endpoint
   logic                take;                    // Held packet leaves

   assign take     = valid_q & ep_ready[sel_q];
   assign in_ready = run_q & (~valid_q | take);  // Empty or draining now

   // Only the selected endpoint sees valid
   assign ep_valid  = valid_q ? N_ENDPOINTS'(1) << sel_q : '0;
   assign ep_packet = packet_q;

   //####################################################################
   // Control state
   //####################################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         run_q   <= 1'b0;
         valid_q <= 1'b0;
      end
      else
      begin
         run_q <= 1'b1;
         if (in_valid && in_ready)
            valid_q <= 1'b1;                     // Refill, also on same-cycle take
         else if (take)
            valid_q <= 1'b0;
      end
   end

   // Packet and its select, loaded on accept
   always_ff @(posedge clk)
   begin
      if (in_valid && in_ready)
      begin
         packet_q <= in_packet;
         sel_q    <= in_packet[DST_LSB+EP_SEL_LSB +: EP_SEL_W];
      end
   end

endmodule

`default_nettype wire

/* hdl/umi_response_arbiter.sv */
`default_nettype none

module umi_response_arbiter
   import umi_pkg::*;
(
   input  logic                               clk,
   input  logic                               nreset,
   // Endpoint responses
   input  logic [N_ENDPOINTS-1:0]             ep_valid,
   input  logic [N_ENDPOINTS-1:0][UMI_UW-1:0] ep_packet,
   output logic [N_ENDPOINTS-1:0]             ep_ready,
   // Merged output
   output logic                               out_valid,
   output logic [UMI_UW-1:0]                  out_packet,
   input  logic                               out_ready
);

   logic                out_valid_q;
   logic [UMI_UW-1:0]   out_packet_q;
   logic [EP_SEL_W-1:0] ptr_q;                  // Last winner
   logic [EP_SEL_W-1:0] gnt_idx;
   logic [N_ENDPOINTS-1:0] grant;               // One-hot winner
   logic                slot_free;              // Output empty or draining

   assign slot_free = ~out_valid_q | out_ready;

   //####################################################################
   // Round-robin pick, search starts after last winner
   //####################################################################
   always_comb
   begin
      logic [EP_SEL_W-1:0] idx;
      logic                found;
      found   = 1'b0;
      gnt_idx = ptr_q;
      for (int k = 1; k <= N_ENDPOINTS; k++)
      begin
         idx = ptr_q + EP_SEL_W'(k);            // Wraps at N_ENDPOINTS
         if (!found && ep_valid[idx])
         begin
            found   = 1'b1;
            gnt_idx = idx;
         end
      end
      grant = found ? N_ENDPOINTS'(1) << gnt_idx : '0;
   end

   // Idle endpoints see ready so they may load
   assign ep_ready = ~ep_valid | (grant & {N_ENDPOINTS{slot_free}});

   //####################################################################
   // Output stage
   //####################################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         out_valid_q <= 1'b0;
         ptr_q       <= EP_SEL_W'(N_ENDPOINTS-1); // Endpoint 0 wins first
      end
      else if (slot_free)
      begin
         out_valid_q <= |ep_valid;
         if (|ep_valid)
            ptr_q <= gnt_idx;
      end
   end

   always_ff @(posedge clk)
   begin
      if (slot_free && |ep_valid)
         out_packet_q <= ep_packet[gnt_idx];
   end

   assign out_valid  = out_valid_q;
   assign out_packet = out_packet_q;

endmodule

`default_nettype wire

/* hdl/umi_scratch_mem.sv */
`default_nettype none

module umi_scratch_mem
   import umi_pkg::*;
(
   input  logic              clk,
   input  logic              nreset,
   input  logic              write,            // Write strobe
   input  logic              read,             // Read strobe
   input  logic [WORD_W-1:0] index,            // Word select
   input  logic [UMI_DW-1:0] wdata,
   output logic              ready,
   output logic [UMI_DW-1:0] rdata
);

   logic [UMI_DW-1:0] mem_q [MEM_WORDS];       // Register file
   logic              busy_q;                  // Write recovery cycle

   //####################################################################
   // Storage
   //####################################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int i = 0; i < MEM_WORDS; i++)
            mem_q[i] <= '0;                     // All words start at zero
      end
      else if (write)
         mem_q[index] <= wdata;
   end

   // One dead cycle after each write
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         busy_q <= 1'b0;
      else
         busy_q <= write;
   end

   assign ready = ~busy_q;

   // Combinational read, quiet when not strobed
   assign rdata = read ? mem_q[index] : '0;

endmodule

`default_nettype wire

/* sim/umi_mem_assertions.sv */
`default_nettype none

module umi_mem_assertions
   import umi_pkg::*;
(
   input logic              clk,
   input logic              nreset,
   input logic              in_valid,
   input logic [UMI_UW-1:0] in_packet,
   input logic              in_ready,
   input logic              out_valid,
   input logic [UMI_UW-1:0] out_packet,
   input logic              out_ready
);
   timeunit 1ns;
   timeprecision 1ps;

   int   reads_open;                             // Reads taken minus responses sent
   int   fail_count;                             // Count of failed assertions
   logic read_xfer;
   logic out_xfer;

   assign read_xfer = in_valid & in_ready & (in_packet[OPCODE_LSB +: OPCODE_W] == OP_READ);
   assign out_xfer  = out_valid & out_ready;

   always @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         reads_open <= 0;
      else
         reads_open <= reads_open + (read_xfer ? 1 : 0) - (out_xfer ? 1 : 0);
   end

   // Stalled output holds its packet
   stall_hold: assert property (@(posedge clk) disable iff (!nreset)
      out_valid && !out_ready |=> out_valid && $stable(out_packet))
      else
      begin
         $error("out_valid or out_packet changed while out_ready was low");
         fail_count++;
      end

   // Quiet ports once reset has been seen
   reset_quiet: assert property (@(posedge clk)
      !nreset && !$past(nreset) |-> !in_ready && !out_valid)
      else
      begin
         $error("in_ready or out_valid high during reset");
         fail_count++;
      end

   rsp_has_read: assert property (@(posedge clk) disable iff (!nreset)
      out_valid |-> reads_open > 0)
      else
      begin
         $error("out_valid without an outstanding read");
         fail_count++;
      end

endmodule

`default_nettype wire

/* sim/umi_mem_checker.sv */
`default_nettype none

module umi_mem_checker
   import umi_pkg::*;
(
   input  logic              clk,
   input  logic              nreset,
   // Request port of the DUT
   input  logic              in_valid,
   input  logic [UMI_UW-1:0] in_packet,
   input  logic              in_ready,
   // Response port of the DUT
   input  logic              out_valid,
   input  logic [UMI_UW-1:0] out_packet,
   input  logic              out_ready,
   input  logic [UMI_DW-1:0] table_rdata,      // Read data the stimulus table expects
   input  logic              end_check,        // Final sweep for lost responses
   output int                error_count,
   output int                rsp_count,
   output int                pending           // Reads still awaiting a response
);
   timeunit 1ns;
   timeprecision 1ps;

   logic [UMI_DW-1:0]   model [N_ENDPOINTS][MEM_WORDS];   // Shadow of the four memories
   logic [UMI_UW-1:0]   exp_rsp [logic [UMI_AW-1:0]];     // Keyed by tag
   logic [UMI_DW-1:0]   exp_data [logic [UMI_AW-1:0]];    // Table read data per tag
   logic [EP_SEL_W-1:0] exp_ep [logic [UMI_AW-1:0]];      // Endpoint of each open read
   logic [UMI_AW-1:0]   last_tag [N_ENDPOINTS];           // Newest tag per endpoint
   int                  unknown_count;
   logic                end_done;

   // Flags and prints one differing field
   function automatic int field_diff(input string name, input logic [UMI_AW-1:0] got,
                                     input logic [UMI_AW-1:0] want);
      if (got !== want)
      begin
         $display("MISMATCH %s got %h expected %h", name, got, want);
         return 1;
      end
      return 0;
   endfunction

   always @(posedge clk)
   begin
      logic [EP_SEL_W-1:0] ep;
      logic [WORD_W-1:0]   word;
      logic [UMI_AW-1:0]   tag;
      logic [UMI_UW-1:0]   want;
      int                  fails;
      if (!nreset)
      begin
         model = '{default: '0};                // Memories clear on reset
         last_tag = '{default: '0};
         exp_rsp.delete();
         exp_data.delete();
         exp_ep.delete();
         error_count   = 0;
         rsp_count     = 0;
         pending       = 0;
         unknown_count = 0;
         end_done      = 1'b0;
      end
      else
      begin
         //##################################################################
         // Request side
         //##################################################################
         if (in_valid && in_ready)
         begin
            ep   = in_packet[DST_LSB+EP_SEL_LSB +: EP_SEL_W];
            word = in_packet[DST_LSB+WORD_LSB +: WORD_W];
            tag  = in_packet[SRC_LSB +: UMI_AW];     // Source address is the tag
            if (in_packet[OPCODE_LSB +: OPCODE_W] == OP_WRITE)
               model[ep][word] = in_packet[DATA_LSB +: UMI_DW];
            else if (in_packet[OPCODE_LSB +: OPCODE_W] == OP_READ)
            begin
               // Turnaround: dest from source, source zero
               want = {model[ep][word], {UMI_AW{1'b0}}, tag,
                       in_packet[USER_LSB +: USER_W], in_packet[SIZE_LSB +: SIZE_W],
                       OP_RESP_READ};
               exp_rsp[tag]  = want;
               exp_data[tag] = table_rdata;
               exp_ep[tag]   = ep;
            end
         end

         //##################################################################
         // Response side
         //##################################################################
         if (out_valid && out_ready)
         begin
            tag = out_packet[DST_LSB +: UMI_AW];
            rsp_count++;
            if (!exp_rsp.exists(tag))
            begin
               $display("a response arrived with the unknown tag %h", tag);
               unknown_count++;
               error_count++;
            end
            else
            begin
               want  = exp_rsp[tag];
               fails = 0;
               fails += field_diff("command", out_packet[CMD_LSB +: CMD_W],
                                   want[CMD_LSB +: CMD_W]);
               fails += field_diff("srcaddr", out_packet[SRC_LSB +: UMI_AW],
                                   want[SRC_LSB +: UMI_AW]);
               fails += field_diff("data", out_packet[DATA_LSB +: UMI_DW],
                                   want[DATA_LSB +: UMI_DW]);
               fails += field_diff("table data", out_packet[DATA_LSB +: UMI_DW],
                                   exp_data[tag]);
               if (tag <= last_tag[exp_ep[tag]])    // Older tag behind a newer one
               begin
                  $display("response tag %h from endpoint %0d came after a later request",
                           tag, exp_ep[tag]);
                  fails++;
               end
               last_tag[exp_ep[tag]] = tag;
               $display("response tag %h endpoint %0d %s", tag, exp_ep[tag],
                        fails == 0 ? "ok" : "failed");
               error_count += fails;
               exp_rsp.delete(tag);
               exp_data.delete(tag);
               exp_ep.delete(tag);
            end
         end
         pending = exp_rsp.num();

         // End of run sweep
         if (end_check && !end_done)
         begin
            end_done = 1'b1;
            foreach (exp_rsp[t])
            begin
               $display("the response for tag %h never arrived", t);
               error_count++;
            end
            if (unknown_count != 0)
               $display("%0d responses arrived with an unknown tag", unknown_count);
         end
      end
   end

endmodule

`default_nettype wire

/* sim/umi_mem_tb.sv */
`default_nettype none

module umi_mem_tb
   import umi_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   typedef struct packed {
      logic [OPCODE_W-1:0] opcode;
      logic [EP_SEL_W-1:0] ep;
      logic [WORD_W-1:0]   word;
      logic [UMI_DW-1:0]   wdata;
      logic [USER_W-1:0]   user;
      logic [SIZE_W-1:0]   size;
      logic [UMI_DW-1:0]   rdata;                // Expected read data
   } stim_t;

   localparam int                  N_STIM      = 16;
   localparam int                  CYCLE_LIMIT = N_STIM * 20 + 200;
   localparam logic [UMI_AW-1:0]   TAG_BASE    = 32'h5000_0000;
   localparam logic [UMI_AW-1:0]   ADDR_BASE   = 32'h2000_0000;   // Upper bits ignored by DUT
   localparam logic [OPCODE_W-1:0] OP_BAD      = 8'h07;           // Not a read or write

   //####################################################################
   // Stimulus table
   //####################################################################
   stim_t stim_table [N_STIM] = '{
      //  opcode   ep    word  wdata          user       size  rdata
      '{OP_READ,  2'd0, 4'd3, 32'h0000_0000, 20'h00a01, 4'd2, 32'h0000_0000},  // Unwritten
      '{OP_WRITE, 2'd0, 4'd3, 32'h1111_1111, 20'h00000, 4'd2, 32'h0000_0000},
      '{OP_WRITE, 2'd1, 4'd3, 32'h2222_2222, 20'h00000, 4'd2, 32'h0000_0000},
      '{OP_WRITE, 2'd2, 4'd3, 32'h3333_3333, 20'h00000, 4'd2, 32'h0000_0000},
      '{OP_WRITE, 2'd3, 4'd3, 32'h4444_4444, 20'h00000, 4'd2, 32'h0000_0000},
      '{OP_READ,  2'd0, 4'd3, 32'h0000_0000, 20'h12345, 4'd0, 32'h1111_1111},
      '{OP_READ,  2'd1, 4'd3, 32'h0000_0000, 20'hfedcb, 4'd1, 32'h2222_2222},
      '{OP_READ,  2'd2, 4'd3, 32'h0000_0000, 20'h0beef, 4'd2, 32'h3333_3333},
      '{OP_READ,  2'd3, 4'd3, 32'h0000_0000, 20'h80001, 4'd3, 32'h4444_4444},
      '{OP_BAD,   2'd1, 4'd3, 32'hdead_beef, 20'h00000, 4'd2, 32'h0000_0000},  // Dropped
      '{OP_READ,  2'd1, 4'd3, 32'h0000_0000, 20'h0c0de, 4'd2, 32'h2222_2222},  // Old value
      '{OP_WRITE, 2'd3, 4'd9, 32'hcafe_f00d, 20'h00000, 4'd2, 32'h0000_0000},
      '{OP_READ,  2'd2, 4'd9, 32'h0000_0000, 20'h00777, 4'd2, 32'h0000_0000},  // Neighbor clean
      '{OP_READ,  2'd3, 4'd9, 32'h0000_0000, 20'h55555, 4'd2, 32'hcafe_f00d},
      '{OP_READ,  2'd0, 4'd3, 32'h0000_0000, 20'haaaaa, 4'd2, 32'h1111_1111},
      '{OP_READ,  2'd3, 4'd3, 32'h0000_0000, 20'h0f0f0, 4'd1, 32'h4444_4444}
   };

   logic              clk;
   logic              nreset;
   logic              in_valid;
   logic [UMI_UW-1:0] in_packet;
   logic              in_ready;
   logic              out_valid;
   logic [UMI_UW-1:0] out_packet;
   logic              out_ready;
   logic [UMI_DW-1:0] table_rdata;              // Sideband to the checker
   logic              end_check;
   logic [31:0]       rnd;                      // Back-pressure state
   int                error_count;
   int                rsp_count;
   int                pending;
   int                cycles;

   umi_mem_subsystem dut_i (
      .clk        (clk),
      .nreset     (nreset),
      .in_valid   (in_valid),
      .in_packet  (in_packet),
      .in_ready   (in_ready),
      .out_valid  (out_valid),
      .out_packet (out_packet),
      .out_ready  (out_ready)
   );

   umi_mem_checker checker_i (.*);

   bind umi_mem_subsystem umi_mem_assertions assertions_i (.*);

   // Request packet from a table row
   function automatic logic [UMI_UW-1:0] make_request(input stim_t s,
                                                      input logic [UMI_AW-1:0] tag);
      logic [UMI_AW-1:0] dst;
      dst = ADDR_BASE | {22'd0, s.ep, 2'b00, s.word, 2'b00};   // Select 9:8, word 5:2
      return {s.wdata, tag, dst, s.user, s.size, s.opcode};
   endfunction

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   //####################################################################
   // Clock, back-pressure, timeout
   //####################################################################
   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;                   // 40 ns period
   end

   initial
   begin
      out_ready = 1'b1;
      rnd       = 32'hfa6e;
      @(posedge nreset);
      forever
      begin
         @(negedge clk);
         rnd       = xorshift(rnd);
         out_ready = (rnd[1:0] != 2'b00);       // Low about one cycle in four
      end
   end

   initial
   begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout after %0d cycles with %0d responses outstanding", cycles, pending);
      $display(">>> FAIL");
      $finish;
   end

   //####################################################################
   // Main sequence
   //####################################################################
   initial
   begin
      logic accepted;
      nreset      = 1'b0;
      in_valid    = 1'b0;
      in_packet   = '0;
      table_rdata = '0;
      end_check   = 1'b0;
      repeat (16) @(negedge clk);
      nreset = 1'b1;
      for (int i = 0; i < N_STIM; i++)
      begin
         @(negedge clk);
         in_valid    = 1'b1;
         in_packet   = make_request(stim_table[i], TAG_BASE + UMI_AW'(i));   // Index as tag
         table_rdata = stim_table[i].rdata;
         accepted    = 1'b0;
         while (!accepted)
         begin
            @(posedge clk);
            accepted = in_ready;
         end
         if (stim_table[i].opcode != OP_READ)
            $display("request %0d opcode %h to endpoint %0d taken", i,
                     stim_table[i].opcode, stim_table[i].ep);
      end
      @(negedge clk);
      in_valid = 1'b0;
      while (pending != 0)
         @(negedge clk);
      repeat (10) @(negedge clk);               // Room for stray responses
      end_check = 1'b1;
      repeat (2) @(negedge clk);
      $display("requests %0d, responses %0d, errors %0d", N_STIM, rsp_count,
               error_count + dut_i.assertions_i.fail_count);
      if (error_count == 0 && dut_i.assertions_i.fail_count == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* umi_mem.f */
hdl/umi_pkg.sv
hdl/umi_scratch_mem.sv
hdl/umi_endpoint.sv
hdl/umi_request_router.sv
hdl/umi_response_arbiter.sv
hdl/umi_mem_subsystem.sv
sim/umi_mem_checker.sv
sim/umi_mem_assertions.sv
sim/umi_mem_tb.sv
